// File: rtl/cheriot_rf_pkg.sv
// Shared definitions for the capability register file subsystem
// Register file sizes, heap and revocation map constants,
// capability and walker control records, walker state encoding

`default_nettype none

package cheriot_rf_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes and address map
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NREGS    = 16;
  localparam int unsigned RegAddrW = 4;

  localparam logic [31:0] HeapBase = 32'h2001_0000;

  // One map bit per 8-byte granule, 32 bits per map word
  localparam int unsigned TSMapWords = 64;
  localparam int unsigned TSMapAddrW = 6;
  localparam int unsigned MapBitLsb  = 3;
  localparam int unsigned MapWordLsb = 8;

  // Heap spans 16 KB
  localparam logic [31:0] HeapSize = 32'(TSMapWords << MapWordLsb);
  localparam logic [31:0] HeapTop  = HeapBase + HeapSize;

  //////////////////////////////////////////////////////////////////////
  // Records and encodings
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        tag;
    logic [5:0]  perms;
    logic [31:0] base;
  } reg_cap_t;

  typedef struct packed {
    logic                start;
    logic [RegAddrW-1:0] first_reg;
    logic [RegAddrW-1:0] last_reg;
  } tbre_ctrl_t;

  typedef enum logic [2:0] {
    TBRE_IDLE,
    TBRE_SCAN,
    TBRE_LOOKUP,
    TBRE_REVOKE,
    TBRE_DONE
  } tbre_state_e;

endpackage

`default_nettype wire

// File: rtl/cap_regfile.sv
// Capability register file
// Data word and capability record per register, two read ports,
// a scan read port, one write port and the ready scoreboard

`timescale 1ns/1ps
`default_nettype none

module cap_regfile (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Read ports
  input  logic [cheriot_rf_pkg::RegAddrW-1:0] raddr_a_i,
  output logic [31:0]                         rdata_a_o,
  output cheriot_rf_pkg::reg_cap_t            rcap_a_o,
  input  logic [cheriot_rf_pkg::RegAddrW-1:0] raddr_b_i,
  output logic [31:0]                         rdata_b_o,
  output cheriot_rf_pkg::reg_cap_t            rcap_b_o,
  input  logic [cheriot_rf_pkg::RegAddrW-1:0] scan_addr_i,
  output cheriot_rf_pkg::reg_cap_t            scan_cap_o,

  // Write port
  input  logic                                we_i,
  input  logic [cheriot_rf_pkg::RegAddrW-1:0] waddr_i,
  input  logic [31:0]                         wdata_i,
  input  cheriot_rf_pkg::reg_cap_t            wcap_i,

  // Reserve and revoke from the walker
  input  logic                                trsv_en_i,
  input  logic [cheriot_rf_pkg::RegAddrW-1:0] trsv_addr_i,
  input  logic                                trvk_en_i,
  input  logic [cheriot_rf_pkg::RegAddrW-1:0] trvk_addr_i,
  input  logic                                trvk_clrtag_i,
  output logic [cheriot_rf_pkg::NREGS-1:0]    reg_rdy_o
);
  import cheriot_rf_pkg::*;

  logic [31:0]      data_q [NREGS];
  reg_cap_t         cap_q  [NREGS];
  logic [NREGS-1:0] rdy_q;
  logic [NREGS-1:0] we_dec;
  logic [NREGS-1:0] rsv_dec;
  logic [NREGS-1:0] rvk_dec;

  // Per-register strobes, entry 0 never selected so it stays zero
  always_comb begin
    we_dec  = '0;
    rsv_dec = '0;
    rvk_dec = '0;
    for (int i = 1; i < NREGS; i++) begin
      we_dec[i]  = we_i && (waddr_i == RegAddrW'(i));
      rsv_dec[i] = trsv_en_i && (trsv_addr_i == RegAddrW'(i));
      rvk_dec[i] = trvk_en_i && (trvk_addr_i == RegAddrW'(i));
    end
  end

  // External write wins over a tag clear to the same entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NREGS; i++) begin
        data_q[i] <= '0;
        cap_q[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < NREGS; i++) begin
        if (we_dec[i]) begin
          data_q[i] <= wdata_i;
          cap_q[i]  <= wcap_i;
        end else if (rvk_dec[i] && trvk_clrtag_i) begin
          cap_q[i].tag <= 1'b0;
        end
      end
    end
  end

  // Scoreboard
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdy_q <= '1;
    end else begin
      for (int i = 0; i < NREGS; i++) begin
        if (rvk_dec[i]) begin
          rdy_q[i] <= 1'b1;
        end else if (rsv_dec[i]) begin
          rdy_q[i] <= 1'b0;
        end
      end
    end
  end

  assign reg_rdy_o = rdy_q;

  assign rdata_a_o  = data_q[raddr_a_i];
  assign rcap_a_o   = cap_q[raddr_a_i];
  assign rdata_b_o  = data_q[raddr_b_i];
  assign rcap_b_o   = cap_q[raddr_b_i];
  assign scan_cap_o = cap_q[scan_addr_i];

endmodule

`default_nettype wire

// File: rtl/tbre_walker.sv
// Background revocation walker
// Steps through a register range, reserves each tagged heap capability,
// looks it up in the revocation map and revokes it

`timescale 1ns/1ps
`default_nettype none

module tbre_walker (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  cheriot_rf_pkg::tbre_ctrl_t          ctrl_i,

  // Register file side
  output logic [cheriot_rf_pkg::RegAddrW-1:0] scan_addr_o,
  input  cheriot_rf_pkg::reg_cap_t            scan_cap_i,
  output logic                                trsv_en_o,
  output logic [cheriot_rf_pkg::RegAddrW-1:0] trsv_addr_o,
  output logic                                trvk_en_o,
  output logic [cheriot_rf_pkg::RegAddrW-1:0] trvk_addr_o,
  output logic                                trvk_clrtag_o,

  // Map port side
  output logic                                lookup_req_o,
  output logic [31:0]                         lookup_base_o,
  input  logic                                lookup_valid_i,
  input  logic                                lookup_revoked_i,

  output logic                                active_o,
  output logic                                done_o
);
  import cheriot_rf_pkg::*;

  tbre_state_e         state_q, state_d;
  logic [RegAddrW-1:0] cur_q, cur_d;
  logic [RegAddrW-1:0] last_q, last_d;
  logic                revoked_q;
  logic                in_heap;
  logic                needs_check;
  logic                at_last;

  assign in_heap     = (scan_cap_i.base >= HeapBase) && (scan_cap_i.base < HeapTop);
  assign needs_check = scan_cap_i.tag && in_heap && (cur_q != '0);
  assign at_last     = (cur_q == last_q);

  always_comb begin
    state_d      = state_q;
    cur_d        = cur_q;
    last_d       = last_q;
    trsv_en_o    = 1'b0;
    trvk_en_o    = 1'b0;
    lookup_req_o = 1'b0;
    done_o       = 1'b0;

    unique case (state_q)
      TBRE_IDLE: begin
        if (ctrl_i.start) begin
          cur_d  = ctrl_i.first_reg;
          last_d = ctrl_i.last_reg;
          // Empty range finishes at once
          state_d = (ctrl_i.first_reg > ctrl_i.last_reg) ? TBRE_DONE : TBRE_SCAN;
        end
      end
      TBRE_SCAN: begin
        if (needs_check) begin
          trsv_en_o    = 1'b1;
          lookup_req_o = 1'b1;
          state_d      = TBRE_LOOKUP;
        end else if (at_last) begin
          state_d = TBRE_DONE;
        end else begin
          cur_d = cur_q + 1'b1;
        end
      end
      // Map answer comes on the second cycle here
      TBRE_LOOKUP: begin
        if (lookup_valid_i) begin
          state_d = TBRE_REVOKE;
        end
      end
      TBRE_REVOKE: begin
        trvk_en_o = 1'b1;
        if (at_last) begin
          state_d = TBRE_DONE;
        end else begin
          cur_d   = cur_q + 1'b1;
          state_d = TBRE_SCAN;
        end
      end
      TBRE_DONE: begin
        done_o  = 1'b1;
        state_d = TBRE_IDLE;
      end
      default: state_d = TBRE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= TBRE_IDLE;
      cur_q     <= '0;
      last_q    <= '0;
      revoked_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cur_q   <= cur_d;
      last_q  <= last_d;
      if (lookup_valid_i) begin
        revoked_q <= lookup_revoked_i;
      end
    end
  end

  assign scan_addr_o   = cur_q;
  assign trsv_addr_o   = cur_q;
  assign trvk_addr_o   = cur_q;
  assign trvk_clrtag_o = revoked_q;
  assign lookup_base_o = scan_cap_i.base;
  assign active_o      = (state_q != TBRE_IDLE);

endmodule

`default_nettype wire

// File: rtl/tsmap_port.sv
// Revocation map port
// Heap offset to map word address, registered memory request,
// selection of the revocation bit from the returned word

`timescale 1ns/1ps
`default_nettype none

module tsmap_port (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  input  logic                                  lookup_req_i,
  input  logic [31:0]                           lookup_base_i,
  output logic                                  lookup_valid_o,
  output logic                                  lookup_revoked_o,

  output logic                                  tsmap_cs_o,
  output logic [cheriot_rf_pkg::TSMapAddrW-1:0] tsmap_addr_o,
  input  logic [31:0]                           tsmap_rdata_i
);
  import cheriot_rf_pkg::*;

  logic [31:0]                       heap_offset;
  logic                              cs_q;
  logic                              valid_q;
  logic [TSMapAddrW-1:0]             addr_q;
  logic [MapWordLsb-MapBitLsb-1:0]   bit_idx_q;

  // Granule index split into word and bit within the word
  assign heap_offset = lookup_base_i - HeapBase;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_q    <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      cs_q    <= lookup_req_i;
      valid_q <= cs_q;
    end
  end

  // Held until the word returns
  always_ff @(posedge clk_i) begin
    if (lookup_req_i) begin
      addr_q    <= heap_offset[MapWordLsb +: TSMapAddrW];
      bit_idx_q <= heap_offset[MapWordLsb-1:MapBitLsb];
    end
  end

  assign tsmap_cs_o   = cs_q;
  assign tsmap_addr_o = addr_q;

  // Word arrives the cycle after the chip select
  assign lookup_valid_o   = valid_q;
  assign lookup_revoked_o = valid_q & tsmap_rdata_i[bit_idx_q];

endmodule

`default_nettype wire

// File: rtl/cheriot_rf_top.sv
// Top level of the capability register file subsystem
// Register file, revocation walker and map port, plus the
// core-busy register and the sleep output

`timescale 1ns/1ps
`default_nettype none

module cheriot_rf_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  input  logic                                  core_busy_i,
  input  logic                                  irq_pending_i,
  output logic                                  core_sleep_o,

  // Pipeline write port
  input  logic                                  rf_we_i,
  input  logic [cheriot_rf_pkg::RegAddrW-1:0]   rf_waddr_i,
  input  logic [31:0]                           rf_wdata_i,
  input  cheriot_rf_pkg::reg_cap_t              rf_wcap_i,

  // Pipeline read ports
  input  logic [cheriot_rf_pkg::RegAddrW-1:0]   rf_raddr_a_i,
  output logic [31:0]                           rf_rdata_a_o,
  output cheriot_rf_pkg::reg_cap_t              rf_rcap_a_o,
  input  logic [cheriot_rf_pkg::RegAddrW-1:0]   rf_raddr_b_i,
  output logic [31:0]                           rf_rdata_b_o,
  output cheriot_rf_pkg::reg_cap_t              rf_rcap_b_o,
  output logic [cheriot_rf_pkg::NREGS-1:0]      reg_rdy_o,

  // Revocation control and map memory
  input  cheriot_rf_pkg::tbre_ctrl_t            tbre_ctrl_i,
  output logic                                  tbre_done_o,
  output logic                                  tsmap_cs_o,
  output logic [cheriot_rf_pkg::TSMapAddrW-1:0] tsmap_addr_o,
  input  logic [31:0]                           tsmap_rdata_i
);
  import cheriot_rf_pkg::*;

  logic                core_busy_q;
  logic                tbre_active;

  logic [RegAddrW-1:0] scan_addr;
  reg_cap_t            scan_rdata;
  logic                trsv_en;
  logic [RegAddrW-1:0] trsv_addr;
  logic                trvk_en;
  logic [RegAddrW-1:0] trvk_addr;
  logic                trvk_clrtag;

  logic                lookup_req;
  logic [31:0]         lookup_base;
  logic                lookup_valid;
  logic                lookup_revoked;

  //////////////////////////////////////////////////////////////////////
  // Sleep indication
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Awake while the core, an interrupt or the walker needs the clock
  assign core_sleep_o = ~(core_busy_q | irq_pending_i | tbre_active);

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  cap_regfile u_cap_regfile (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .raddr_a_i    (rf_raddr_a_i),
    .rdata_a_o    (rf_rdata_a_o),
    .rcap_a_o     (rf_rcap_a_o),
    .raddr_b_i    (rf_raddr_b_i),
    .rdata_b_o    (rf_rdata_b_o),
    .rcap_b_o     (rf_rcap_b_o),
    .scan_addr_i  (scan_addr),
    .scan_cap_o   (scan_rdata),
    .we_i         (rf_we_i),
    .waddr_i      (rf_waddr_i),
    .wdata_i      (rf_wdata_i),
    .wcap_i       (rf_wcap_i),
    .trsv_en_i    (trsv_en),
    .trsv_addr_i  (trsv_addr),
    .trvk_en_i    (trvk_en),
    .trvk_addr_i  (trvk_addr),
    .trvk_clrtag_i(trvk_clrtag),
    .reg_rdy_o    (reg_rdy_o)
  );

  tbre_walker u_tbre_walker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ctrl_i          (tbre_ctrl_i),
    .scan_addr_o     (scan_addr),
    .scan_cap_i      (scan_rdata),
    .trsv_en_o       (trsv_en),
    .trsv_addr_o     (trsv_addr),
    .trvk_en_o       (trvk_en),
    .trvk_addr_o     (trvk_addr),
    .trvk_clrtag_o   (trvk_clrtag),
    .lookup_req_o    (lookup_req),
    .lookup_base_o   (lookup_base),
    .lookup_valid_i  (lookup_valid),
    .lookup_revoked_i(lookup_revoked),
    .active_o        (tbre_active),
    .done_o          (tbre_done_o)
  );

  tsmap_port u_tsmap_port (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lookup_req_i    (lookup_req),
    .lookup_base_i   (lookup_base),
    .lookup_valid_o  (lookup_valid),
    .lookup_revoked_o(lookup_revoked),
    .tsmap_cs_o      (tsmap_cs_o),
    .tsmap_addr_o    (tsmap_addr_o),
    .tsmap_rdata_i   (tsmap_rdata_i)
  );

endmodule

`default_nettype wire

// File: bench/tsmap_mem_model.sv
// Revocation map memory model
// Synchronous read port for the map port, load port for the testbench

`timescale 1ns/1ps
`default_nettype none

module tsmap_mem_model (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Map port side
  input  logic                                  cs_i,
  input  logic [cheriot_rf_pkg::TSMapAddrW-1:0] addr_i,
  output logic [31:0]                           rdata_o,

  // Contents loaded before the scans
  input  logic                                  load_en_i,
  input  logic [cheriot_rf_pkg::TSMapAddrW-1:0] load_addr_i,
  input  logic [31:0]                           load_data_i
);
  import cheriot_rf_pkg::*;

  logic [31:0] mem_q [TSMapWords];

  always_ff @(posedge clk_i) begin
    if (load_en_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end
  end

  // Word comes back the cycle after the chip select
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (cs_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: bench/cheriot_rf_tb.sv
// Testbench for the capability register file subsystem
// Clock and reset, LFSR stimulus, revocation reference model,
// per-cycle monitor for scoreboard, map requests and sleep, directed test sequence

`timescale 1ns/1ps
`default_nettype none

module cheriot_rf_tb;
  import cheriot_rf_pkg::*;

  localparam int unsigned NumScans       = 3;
  localparam int unsigned WatchdogCycles = NumScans * NREGS * 4 + 1500;
  // 32 granules of 8 bytes behind each map word
  localparam int unsigned WordBytes      = 32 * 8;
  localparam logic [31:0] HeapBytes      = 32'(TSMapWords * WordBytes);

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  core_busy;
  logic                  irq_pending;
  logic                  core_sleep;
  logic                  rf_we;
  logic [RegAddrW-1:0]   rf_waddr;
  logic [31:0]           rf_wdata;
  reg_cap_t              rf_wcap;
  logic [RegAddrW-1:0]   rf_raddr_a;
  logic [31:0]           rf_rdata_a;
  reg_cap_t              rf_rcap_a;
  logic [RegAddrW-1:0]   rf_raddr_b;
  logic [31:0]           rf_rdata_b;
  reg_cap_t              rf_rcap_b;
  logic [NREGS-1:0]      reg_rdy;
  tbre_ctrl_t            tbre_ctrl;
  logic                  tbre_done;
  logic                  tsmap_cs;
  logic [TSMapAddrW-1:0] tsmap_addr;
  logic [31:0]           tsmap_rdata;
  logic                  map_load_en;
  logic [TSMapAddrW-1:0] map_load_addr;
  logic [31:0]           map_load_data;

  // Reference state
  logic [15:0]           lfsr_state;
  logic [31:0]           wdata [NREGS];
  reg_cap_t              wcap [NREGS];
  logic [31:0]           map_words [TSMapWords];
  int                    scan_first;
  int                    scan_last;
  int                    done_count;
  logic                  active_model;
  logic                  start_prev;
  logic                  done_prev;
  logic                  busy_prev;
  logic                  reserved_prev;

  always #4 clk = ~clk;

  cheriot_rf_top cheriot_rf_top_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .core_busy_i  (core_busy),
    .irq_pending_i(irq_pending),
    .core_sleep_o (core_sleep),
    .rf_we_i      (rf_we),
    .rf_waddr_i   (rf_waddr),
    .rf_wdata_i   (rf_wdata),
    .rf_wcap_i    (rf_wcap),
    .rf_raddr_a_i (rf_raddr_a),
    .rf_rdata_a_o (rf_rdata_a),
    .rf_rcap_a_o  (rf_rcap_a),
    .rf_raddr_b_i (rf_raddr_b),
    .rf_rdata_b_o (rf_rdata_b),
    .rf_rcap_b_o  (rf_rcap_b),
    .reg_rdy_o    (reg_rdy),
    .tbre_ctrl_i  (tbre_ctrl),
    .tbre_done_o  (tbre_done),
    .tsmap_cs_o   (tsmap_cs),
    .tsmap_addr_o (tsmap_addr),
    .tsmap_rdata_i(tsmap_rdata)
  );

  tsmap_mem_model tsmap_mem_model_inst (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cs_i       (tsmap_cs),
    .addr_i     (tsmap_addr),
    .rdata_o    (tsmap_rdata),
    .load_en_i  (map_load_en),
    .load_addr_i(map_load_addr),
    .load_data_i(map_load_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // Half of the bases land in the heap
  task automatic random_cap(output reg_cap_t cap);
    logic [31:0] bits;
    draw_bits(2, bits);
    cap.tag = (bits[1:0] != 2'b00);
    draw_bits(6, bits);
    cap.perms = bits[5:0];
    draw_bits(1, bits);
    if (bits[0]) begin
      draw_bits(14, bits);
      cap.base = HeapBase + {18'd0, bits[13:0]};
    end else begin
      draw_bits(32, bits);
      cap.base = bits;
    end
  endtask

  function automatic logic base_in_heap(input logic [31:0] base);
    return (base >= HeapBase) && ((base - HeapBase) < HeapBytes);
  endfunction

  // Register that the current scan reserves and looks up
  function automatic logic needs_lookup(input int r);
    return (r != 0) && wcap[r].tag && (r >= scan_first) && (r <= scan_last)
           && base_in_heap(wcap[r].base);
  endfunction

  function automatic logic expected_tag(input int r);
    logic [31:0] offset;
    offset = wcap[r].base - HeapBase;
    if (!needs_lookup(r)) begin
      return wcap[r].tag;
    end
    // A set map bit revokes
    return !map_words[offset / WordBytes][offset[7:3]];
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %0t %s: expected %0h, actual %0h", $time, name, expected, actual);
      $display("Something failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per-cycle monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : cycle_monitor
    int   low_count;
    int   low_reg;
    logic map_req_exp;
    if (!rst_n) begin
      active_model  = 1'b0;
      start_prev    = 1'b0;
      done_prev     = 1'b0;
      busy_prev     = 1'b0;
      reserved_prev = 1'b0;
    end else begin
      // Walker busy from the cycle after an idle start through its done cycle
      if (done_prev) begin
        active_model = 1'b0;
      end else if (start_prev) begin
        active_model = 1'b1;
      end
      check_value("core_sleep_o", !(busy_prev || irq_pending || active_model), core_sleep);

      low_count = 0;
      low_reg   = 0;
      for (int i = 0; i < NREGS; i++) begin
        if (!reg_rdy[i]) begin
          low_count++;
          low_reg = i;
        end
      end
      check_value("reg_rdy_o bits low at most one", 1, low_count <= 1);
      if (low_count == 1) begin
        check_value("reg_rdy_o reserved register eligible", 1,
                    active_model && needs_lookup(low_reg));
      end

      // Map request goes out in the first cycle of a reservation
      map_req_exp = (low_count == 1) && !reserved_prev;
      check_value("tsmap_cs_o", map_req_exp, tsmap_cs);
      if (map_req_exp) begin
        check_value("tsmap_addr_o", (wcap[low_reg].base - HeapBase) / WordBytes,
                    tsmap_addr);
      end
      reserved_prev = (low_count != 0);

      if (tbre_done) begin
        done_count++;
      end
      start_prev = tbre_ctrl.start;
      done_prev  = tbre_done;
      busy_prev  = core_busy;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input int r, input logic [31:0] data, input reg_cap_t cap);
    @(posedge clk);
    rf_we    <= 1'b1;
    rf_waddr <= RegAddrW'(r);
    rf_wdata <= data;
    rf_wcap  <= cap;
    @(posedge clk);
    rf_we    <= 1'b0;
    if (r != 0) begin
      wdata[r] = data;
      wcap[r]  = cap;
    end
  endtask

  task automatic fill_regs(input int first);
    reg_cap_t    cap;
    logic [31:0] data;
    for (int r = first; r < NREGS; r++) begin
      random_cap(cap);
      draw_bits(32, data);
      write_reg(r, data, cap);
    end
  endtask

  task automatic check_regs();
    int rb;
    for (int r = 0; r < NREGS; r++) begin
      rb = (r + 7) % NREGS;
      @(posedge clk);
      rf_raddr_a <= RegAddrW'(r);
      rf_raddr_b <= RegAddrW'(rb);
      @(negedge clk);
      check_value("rf_rdata_a_o", wdata[r], rf_rdata_a);
      check_value("rf_rcap_a_o", wcap[r], rf_rcap_a);
      check_value("rf_rdata_b_o", wdata[rb], rf_rdata_b);
      check_value("rf_rcap_b_o", wcap[rb], rf_rcap_b);
    end
  endtask

  task automatic load_map();
    logic [31:0] word;
    for (int w = 0; w < TSMapWords; w++) begin
      draw_bits(32, word);
      map_words[w] = word;
      @(posedge clk);
      map_load_en   <= 1'b1;
      map_load_addr <= TSMapAddrW'(w);
      map_load_data <= word;
    end
    @(posedge clk);
    map_load_en <= 1'b0;
  endtask

  // Optionally a second start pulse while the walker is still busy
  task automatic run_scan(input int first, input int last, input logic restart);
    int         done_before;
    tbre_ctrl_t ctrl;
    done_before    = done_count;
    scan_first     = first;
    scan_last      = last;
    ctrl.start     = 1'b1;
    ctrl.first_reg = RegAddrW'(first);
    ctrl.last_reg  = RegAddrW'(last);
    @(posedge clk);
    tbre_ctrl <= ctrl;
    @(posedge clk);
    tbre_ctrl <= '0;
    if (restart) begin
      repeat (3) @(posedge clk);
      ctrl.first_reg = RegAddrW'(1);
      ctrl.last_reg  = RegAddrW'(NREGS - 1);
      tbre_ctrl <= ctrl;
      @(posedge clk);
      tbre_ctrl <= '0;
    end
    while (done_count == done_before) begin
      @(negedge clk);
    end
    // Room for a stray second pulse
    repeat (4) @(negedge clk);
    check_value("tbre_done_o pulse count", 1, done_count - done_before);
    check_value("reg_rdy_o after done", {NREGS{1'b1}}, reg_rdy);
    for (int r = 1; r < NREGS; r++) begin
      wcap[r].tag = expected_tag(r);
    end
    check_regs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : test_sequence
    lfsr_state    = 16'd49;
    done_count    = 0;
    scan_first    = 1;
    scan_last     = 0;
    rst_n         = 1'b0;
    core_busy     = 1'b0;
    irq_pending   = 1'b0;
    rf_we         = 1'b0;
    rf_waddr      = '0;
    rf_wdata      = '0;
    rf_wcap       = '0;
    rf_raddr_a    = RegAddrW'(3);
    rf_raddr_b    = RegAddrW'(12);
    tbre_ctrl     = '0;
    map_load_en   = 1'b0;
    map_load_addr = '0;
    map_load_data = '0;
    for (int r = 0; r < NREGS; r++) begin
      wdata[r] = '0;
      wcap[r]  = '0;
    end

    // Reset state
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("reg_rdy_o", {NREGS{1'b1}}, reg_rdy);
    check_value("rf_rdata_a_o", 0, rf_rdata_a);
    check_value("rf_rcap_a_o.tag", 0, rf_rcap_a.tag);
    check_value("rf_rdata_b_o", 0, rf_rdata_b);
    check_value("rf_rcap_b_o.tag", 0, rf_rcap_b.tag);
    check_value("tsmap_cs_o", 0, tsmap_cs);
    check_value("tbre_done_o", 0, tbre_done);
    check_value("core_sleep_o", 1, core_sleep);
    @(posedge clk);
    rst_n <= 1'b1;

    // Write and read back, register 0 included
    fill_regs(0);
    check_regs();
    load_map();

    // Full range
    fill_regs(1);
    run_scan(1, NREGS - 1, 1'b0);

    // Busy is seen one cycle late, the interrupt at once
    @(posedge clk);
    core_busy <= 1'b1;
    repeat (3) @(posedge clk);
    core_busy <= 1'b0;
    repeat (3) @(posedge clk);
    irq_pending <= 1'b1;
    repeat (2) @(posedge clk);
    irq_pending <= 1'b0;
    repeat (3) @(posedge clk);

    // Partial range with an ignored start, then an empty range
    fill_regs(1);
    run_scan(4, 9, 1'b1);
    run_scan(10, 3, 1'b0);

    repeat (2) @(negedge clk);
    $display("Everything OK");
    $finish;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: the test sequence did not finish in %0d cycles", WatchdogCycles);
    $display("Something failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: all.f
rtl/cheriot_rf_pkg.sv
rtl/cap_regfile.sv
rtl/tbre_walker.sv
rtl/tsmap_port.sv
rtl/cheriot_rf_top.sv
bench/tsmap_mem_model.sv
bench/cheriot_rf_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f --top-module cheriot_rf_tb -o cheriot_rf_sim

# The log decides the result, so a failing run must not stop the script here
./obj_dir/cheriot_rf_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
